/* sources.f */
vmem_pkg.sv
map_level1_ram.sv
map_level2_ram.sv
level1_stage.sv
level2_stage.sv
access_check_stage.sv
vmem_map.sv
vmem_map_checker.sv
vmem_map_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module vmem_map_tb -f sources.f -o vmem_map_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/vmem_map_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
exit 0

/* vmem_map_tb.sv */
// ========================================
// Testbench top, clock, reset, stimulus
// and test sequence for the memory map
// ========================================

`timescale 1ns/100ps

module vmem_map_tb;

   logic                  clk_a;
   logic                  reset;
   logic                  xlate_req;
   vmem_pkg::vma_t        xlate_vma;
   logic                  xlate_write;
   logic                  l1_load;
   vmem_pkg::l1_addr_t    l1_load_addr;
   vmem_pkg::l1_entry_t   l1_load_data;
   logic                  l2_load;
   vmem_pkg::l2_addr_t    l2_load_addr;
   vmem_pkg::l2_entry_t   l2_load_data;
   logic                  xlate_done;
   vmem_pkg::phys_addr_t  phys_addr;
   vmem_pkg::meta_t       meta;
   logic                  access_fault;
   logic                  write_fault;
   int                    error_count;
   int                    done_count;
   int                    pending;

   logic [31:0]           rng_state;
   vmem_pkg::l1_addr_t    l1_used [0:63];
   vmem_pkg::l1_entry_t   l1_copy [0:63];
   vmem_pkg::l2_entry_t   l2_copy [0:1023];
   int                    stim_errors;
   int                    errors_seen;
   int                    issued;
   logic                  timed_out;

   vmem_map vmem_map_inst (.*);

   vmem_map_checker vmem_map_checker_inst (.*);

   initial
   begin
      clk_a = 1'b0;
      forever #10 clk_a = ~clk_a;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Inputs change 2 ns after the edge, strobes last one cycle
   task automatic tick();
      @(posedge clk_a);
      #2;
      xlate_req = 1'b0;
      l1_load   = 1'b0;
      l2_load   = 1'b0;
   endtask

   task automatic issue(input vmem_pkg::vma_t vma, input logic write);
      tick();
      xlate_req   = 1'b1;
      xlate_vma   = vma;
      xlate_write = write;
      issued++;
   endtask

   task automatic load_l1(input vmem_pkg::l1_addr_t addr, input vmem_pkg::l1_entry_t data);
      tick();
      l1_load      = 1'b1;
      l1_load_addr = addr;
      l1_load_data = data;
   endtask

   task automatic load_l2(input vmem_pkg::l2_addr_t addr, input vmem_pkg::l2_entry_t data);
      tick();
      l2_load      = 1'b1;
      l2_load_addr = addr;
      l2_load_data = data;
   endtask

   // Kind 0 access clear, 1 access set, 2 write not allowed, 3 write allowed
   task automatic pick_vma(input logic [1:0] kind, output vmem_pkg::vma_t vma);
      logic [31:0]          r;
      vmem_pkg::l2_entry_t  e;
      logic                 hit;
      int                   tries;
      hit   = 1'b0;
      tries = 0;
      vma   = '0;
      while (!hit && tries < 4000)
      begin
         r   = next_rand();
         vma = {l1_used[r[5:0]], r[18:6]};
         e   = l2_copy[{l1_copy[r[5:0]], vma[12:8]}];
         case (kind)
            2'd0:    hit = !e[vmem_pkg::L2_ACCESS_BIT];
            2'd1:    hit = e[vmem_pkg::L2_ACCESS_BIT];
            2'd2:    hit = e[vmem_pkg::L2_ACCESS_BIT] && !e[vmem_pkg::L2_WRITE_BIT];
            default: hit = e[vmem_pkg::L2_ACCESS_BIT] && e[vmem_pkg::L2_WRITE_BIT];
         endcase
         tries++;
      end
      if (!hit)
      begin
         $display("no map entry of kind %0d was found for a request", kind);
         stim_errors++;
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (pending != 0 && n < 50)
      begin
         tick();
         n++;
      end
      if (pending != 0)
      begin
         $display("timed out waiting for translations, %0d still in flight", pending);
         timed_out = 1'b1;
      end
   endtask

   task automatic report_test(input int t, input string name);
      int total;
      total = error_count + stim_errors;
      $display("test %0d, %s: %s", t, name, (total == errors_seen) ? "ok" : "errors");
      errors_seen = total;
   endtask

   task automatic run_test(input int t);
      logic [31:0]          r;
      vmem_pkg::vma_t       vma;
      vmem_pkg::l1_entry_t  blk;
      vmem_pkg::l2_entry_t  entry;
      string                name;
      name = "";
      case (t)
         1:
         begin
            name = "idle after reset";
            repeat (8) tick();
         end
         2:
         begin
            name = "read translations";
            repeat (20)
            begin
               pick_vma(2'd1, vma);
               issue(vma, 1'b0);
               tick();
            end
         end
         3:
         begin
            name = "access faults";
            repeat (12)
            begin
               r = next_rand();
               pick_vma(2'd0, vma);
               issue(vma, r[0]);
               tick();
            end
         end
         4:
         begin
            name = "write faults";
            repeat (10)
            begin
               pick_vma(2'd2, vma);
               issue(vma, 1'b1);
               issue(vma, 1'b0);
               pick_vma(2'd3, vma);
               issue(vma, 1'b1);
               tick();
            end
         end
         5:
         begin
            name = "back-to-back requests";
            repeat (16)
            begin
               r = next_rand();
               pick_vma(r[1:0], vma);
               issue(vma, r[2]);
            end
         end
         default:
         begin
            name = "map rewrite";
            r     = next_rand();
            blk   = l1_copy[0] + 5'd1;
            entry = {2'b11, r[21:0]};
            l1_copy[0] = blk;
            l2_copy[{blk, 5'd0}] = entry;
            load_l1(l1_used[0], blk);
            load_l2({blk, 5'd0}, entry);
            issue({l1_used[0], 5'd0, r[29:22]}, 1'b0);
            issue({l1_used[0], 5'd0, r[29:22]}, 1'b1);
         end
      endcase
      drain();
      report_test(t, name);
   endtask

   initial
   begin
      logic [31:0] r;
      int          total;
      reset        = 1'b1;
      xlate_req    = 1'b0;
      xlate_vma    = '0;
      xlate_write  = 1'b0;
      l1_load      = 1'b0;
      l1_load_addr = '0;
      l1_load_data = '0;
      l2_load      = 1'b0;
      l2_load_addr = '0;
      l2_load_data = '0;
      rng_state    = 32'he0b6c03d;
      stim_errors  = 0;
      errors_seen  = 0;
      issued       = 0;
      timed_out    = 1'b0;
      repeat (3) @(posedge clk_a);
      #2;
      reset = 1'b0;
      for (int i = 0; i < 1024; i++)
      begin
         r = next_rand();
         l2_copy[i] = r[23:0];
         load_l2(i[9:0], r[23:0]);
      end
      // Each loaded level-1 index falls in its own group of 32, so none repeat
      for (int i = 0; i < 64; i++)
      begin
         r = next_rand();
         l1_used[i] = {i[5:0], r[4:0]};
         l1_copy[i] = r[9:5];
         load_l1(l1_used[i], l1_copy[i]);
      end
      for (int t = 1; t <= 6 && !timed_out; t++)
      begin
         run_test(t);
      end
      total = error_count + stim_errors;
      if (done_count != issued)
      begin
         $display("%0d requests were issued but %0d completed", issued, done_count);
         total++;
      end
      $display("summary: %0d translations checked, %0d errors", done_count, total);
      if (timed_out || total != 0)
      begin
         $display("TEST RESULT: FAIL");
      end
      else
      begin
         $display("TEST RESULT: PASS");
      end
      $finish;
   end

endmodule

/* vmem_map_checker.sv */
// ========================================
// Checker for the virtual memory map, with
// shadow maps, reference model and compare
// ========================================

`timescale 1ns/100ps

module vmem_map_checker
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  xlate_req,
   input  vmem_pkg::vma_t        xlate_vma,
   input  logic                  xlate_write,
   input  logic                  l1_load,
   input  vmem_pkg::l1_addr_t    l1_load_addr,
   input  vmem_pkg::l1_entry_t   l1_load_data,
   input  logic                  l2_load,
   input  vmem_pkg::l2_addr_t    l2_load_addr,
   input  vmem_pkg::l2_entry_t   l2_load_data,
   input  logic                  xlate_done,
   input  vmem_pkg::phys_addr_t  phys_addr,
   input  vmem_pkg::meta_t       meta,
   input  logic                  access_fault,
   input  logic                  write_fault,
   output int                    error_count,
   output int                    done_count,
   output int                    pending
);

   vmem_pkg::l1_entry_t  shadow_l1 [0:vmem_pkg::L1_DEPTH-1];
   vmem_pkg::l2_entry_t  shadow_l2 [0:vmem_pkg::L2_DEPTH-1];
   logic [31:0]          expect_q [$];
   int                   issue_q [$];
   logic [31:0]          expected;
   int                   issued_at;
   int                   cycle;
   logic                 stage_valid;
   vmem_pkg::vma_t       stage_vma;
   logic                 stage_write;
   vmem_pkg::l1_entry_t  stage_block;
   int                   stage_cycle;

   // Packs {access_fault, write_fault, meta, phys_addr} for one request
   function automatic logic [31:0] ref_translate(input vmem_pkg::vma_t vma, input logic write,
                                                 input vmem_pkg::l1_entry_t block);
      vmem_pkg::l2_entry_t  e;
      logic                 af;
      logic                 wf;
      e  = shadow_l2[{block, vma[12:8]}];
      af = !e[vmem_pkg::L2_ACCESS_BIT];
      wf = e[vmem_pkg::L2_ACCESS_BIT] && write && !e[vmem_pkg::L2_WRITE_BIT];
      return {af, wf, e[vmem_pkg::L2_META_HI:vmem_pkg::L2_META_LO],
              e[vmem_pkg::L2_PPN_HI:vmem_pkg::L2_PPN_LO], vma[7:0]};
   endfunction

   task automatic compare_field(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, exp, act);
         error_count++;
      end
   endtask

   initial
   begin
      error_count = 0;
      done_count  = 0;
      pending     = 0;
      cycle       = 0;
      stage_valid = 1'b0;
   end

   always @(posedge clk_a)
   begin
      if (reset)
      begin
         expect_q.delete();
         issue_q.delete();
         stage_valid = 1'b0;
      end
      else
      begin
         if (xlate_done)
         begin
            if (expect_q.size() == 0)
            begin
               $display("xlate_done pulsed with no request in flight");
               error_count++;
            end
            else
            begin
               expected  = expect_q.pop_front();
               issued_at = issue_q.pop_front();
               if (cycle - issued_at != 3)
               begin
                  $display("a translation finished %0d cycles after its request instead of 3",
                           cycle - issued_at);
                  error_count++;
               end
               compare_field("phys_addr", {10'h0, expected[21:0]}, {10'h0, phys_addr});
               compare_field("meta", {24'h0, expected[29:22]}, {24'h0, meta});
               compare_field("access_fault", {31'h0, expected[31]}, {31'h0, access_fault});
               compare_field("write_fault", {31'h0, expected[30]}, {31'h0, write_fault});
               done_count++;
            end
         end
         else if (access_fault || write_fault)
         begin
            $display("a fault output was high while xlate_done was low");
            error_count++;
         end
         // The level-2 read happens one edge after the request
         if (stage_valid)
         begin
            expect_q.push_back(ref_translate(stage_vma, stage_write, stage_block));
            issue_q.push_back(stage_cycle);
         end
         stage_valid = xlate_req;
         if (xlate_req)
         begin
            stage_vma   = xlate_vma;
            stage_write = xlate_write;
            stage_block = shadow_l1[xlate_vma[23:13]];
            stage_cycle = cycle;
         end
      end
      // Loads land after this edge's reads, so a read at the same edge sees old data
      if (l1_load)
      begin
         shadow_l1[l1_load_addr] = l1_load_data;
      end
      if (l2_load)
      begin
         shadow_l2[l2_load_addr] = l2_load_data;
      end
      pending = expect_q.size() + (stage_valid ? 1 : 0);
      cycle++;
   end

endmodule

/* vmem_map.sv */
// ========================================
// Virtual memory map top, three-stage
// translation pipeline
// ========================================

`timescale 1ns/100ps

module vmem_map
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  xlate_req,
   input  vmem_pkg::vma_t        xlate_vma,
   input  logic                  xlate_write,
   input  logic                  l1_load,
   input  vmem_pkg::l1_addr_t    l1_load_addr,
   input  vmem_pkg::l1_entry_t   l1_load_data,
   input  logic                  l2_load,
   input  vmem_pkg::l2_addr_t    l2_load_addr,
   input  vmem_pkg::l2_entry_t   l2_load_data,
   output logic                  xlate_done,
   output vmem_pkg::phys_addr_t  phys_addr,
   output vmem_pkg::meta_t       meta,
   output logic                  access_fault,
   output logic                  write_fault
);

   logic                 s1_valid;
   logic [12:0]          s1_vma_low;
   logic                 s1_write;
   vmem_pkg::l1_entry_t  s1_block;
   logic                 s2_valid;
   logic [7:0]           s2_offset;
   logic                 s2_write;
   vmem_pkg::l2_entry_t  s2_entry;

   level1_stage level1_stage_inst
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .xlate_req    (xlate_req),
      .xlate_vma    (xlate_vma),
      .xlate_write  (xlate_write),
      .l1_load      (l1_load),
      .l1_load_addr (l1_load_addr),
      .l1_load_data (l1_load_data),
      .s1_valid     (s1_valid),
      .s1_vma_low   (s1_vma_low),
      .s1_write     (s1_write),
      .s1_block     (s1_block)
   );

   level2_stage level2_stage_inst
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .s1_valid     (s1_valid),
      .s1_vma_low   (s1_vma_low),
      .s1_write     (s1_write),
      .s1_block     (s1_block),
      .l2_load      (l2_load),
      .l2_load_addr (l2_load_addr),
      .l2_load_data (l2_load_data),
      .s2_valid     (s2_valid),
      .s2_offset    (s2_offset),
      .s2_write     (s2_write),
      .s2_entry     (s2_entry)
   );

   access_check_stage access_check_stage_inst
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .s2_valid     (s2_valid),
      .s2_offset    (s2_offset),
      .s2_write     (s2_write),
      .s2_entry     (s2_entry),
      .xlate_done   (xlate_done),
      .phys_addr    (phys_addr),
      .meta         (meta),
      .access_fault (access_fault),
      .write_fault  (write_fault)
   );

endmodule

/* access_check_stage.sv */
// ========================================
// Final stage, physical address and faults
// ========================================

`timescale 1ns/100ps

module access_check_stage
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  s2_valid,
   input  logic [7:0]            s2_offset,
   input  logic                  s2_write,
   input  vmem_pkg::l2_entry_t   s2_entry,
   output logic                  xlate_done,
   output vmem_pkg::phys_addr_t  phys_addr,
   output vmem_pkg::meta_t       meta,
   output logic                  access_fault,
   output logic                  write_fault
);

   logic             access_ok;
   logic             write_ok;
   vmem_pkg::ppn_t   ppn;
   vmem_pkg::meta_t  entry_meta;

   assign access_ok  = s2_entry[vmem_pkg::L2_ACCESS_BIT];
   assign write_ok   = s2_entry[vmem_pkg::L2_WRITE_BIT];
   assign ppn        = s2_entry[vmem_pkg::L2_PPN_HI:vmem_pkg::L2_PPN_LO];
   assign entry_meta = s2_entry[vmem_pkg::L2_META_HI:vmem_pkg::L2_META_LO];

   // Faults only rise alongside done, so they clear on idle cycles
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         xlate_done   <= 1'b0;
         access_fault <= 1'b0;
         write_fault  <= 1'b0;
      end
      else
      begin
         xlate_done   <= s2_valid;
         access_fault <= s2_valid & ~access_ok;
         write_fault  <= s2_valid & access_ok & s2_write & ~write_ok;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (s2_valid)
      begin
         phys_addr <= {ppn, s2_offset};
         meta      <= entry_meta;
      end
   end

   assert property (@(posedge clk_a) disable iff (reset)
      !(access_fault && write_fault));

   // A fault never shows without a completed translation
   assert property (@(posedge clk_a) disable iff (reset)
      !xlate_done |-> !access_fault && !write_fault);

endmodule

/* level2_stage.sv */
// ========================================
// Second translation stage, level-2 lookup
// ========================================

`timescale 1ns/100ps

module level2_stage
(
   input  logic                 clk_a,
   input  logic                 reset,
   input  logic                 s1_valid,
   input  logic [12:0]          s1_vma_low,
   input  logic                 s1_write,
   input  vmem_pkg::l1_entry_t  s1_block,
   input  logic                 l2_load,
   input  vmem_pkg::l2_addr_t   l2_load_addr,
   input  vmem_pkg::l2_entry_t  l2_load_data,
   output logic                 s2_valid,
   output logic [7:0]           s2_offset,
   output logic                 s2_write,
   output vmem_pkg::l2_entry_t  s2_entry
);

   vmem_pkg::l2_addr_t l2_index;

   // Block number picks a group of 32 entries, vma bits 12 to 8 pick one of them
   assign l2_index = {s1_block, s1_vma_low[12:8]};

   map_level2_ram map_level2_ram_inst
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (l2_index),
      .rden_a    (s1_valid),
      .address_b (l2_load_addr),
      .data_b    (l2_load_data),
      .wren_b    (l2_load),
      .q_a       (s2_entry)
   );

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s2_valid <= 1'b0;
      end
      else
      begin
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk_a)
   begin
      s2_offset <= s1_vma_low[7:0];
      s2_write  <= s1_write;
   end

endmodule

/* level1_stage.sv */
// ========================================
// First translation stage, level-1 lookup
// ========================================

`timescale 1ns/100ps

module level1_stage
(
   input  logic                 clk_a,
   input  logic                 reset,
   input  logic                 xlate_req,
   input  vmem_pkg::vma_t       xlate_vma,
   input  logic                 xlate_write,
   input  logic                 l1_load,
   input  vmem_pkg::l1_addr_t   l1_load_addr,
   input  vmem_pkg::l1_entry_t  l1_load_data,
   output logic                 s1_valid,
   output logic [12:0]          s1_vma_low,
   output logic                 s1_write,
   output vmem_pkg::l1_entry_t  s1_block
);

   vmem_pkg::l1_addr_t l1_index;

   // Upper 11 bits of the virtual address select the block
   assign l1_index = xlate_vma[23:13];

   map_level1_ram map_level1_ram_inst
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (l1_index),
      .rden_a    (xlate_req),
      .address_b (l1_load_addr),
      .data_b    (l1_load_data),
      .wren_b    (l1_load),
      .q_a       (s1_block)
   );

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
      end
      else
      begin
         s1_valid <= xlate_req;
      end
   end

   // Request fields ride alongside the RAM read
   always_ff @(posedge clk_a)
   begin
      s1_vma_low <= xlate_vma[12:0];
      s1_write   <= xlate_write;
   end

endmodule

/* map_level2_ram.sv */
// ========================================
// Level-2 map RAM, 1024 x 24, read port A
// and write port B
// ========================================

`timescale 1ns/100ps

module map_level2_ram
(
   input  logic                 clk_a,
   input  logic                 reset,
   input  vmem_pkg::l2_addr_t   address_a,
   input  logic                 rden_a,
   input  vmem_pkg::l2_addr_t   address_b,
   input  vmem_pkg::l2_entry_t  data_b,
   input  logic                 wren_b,
   output vmem_pkg::l2_entry_t  q_a
);

   vmem_pkg::l2_entry_t ram [0:vmem_pkg::L2_DEPTH-1];
   vmem_pkg::l2_entry_t out_a;

   assign q_a = out_a;

   always_ff @(posedge clk_a)
   begin
      if (wren_b)
      begin
         ram[address_b] <= data_b;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         out_a <= '0;
      end
      else if (rden_a)
      begin
         out_a <= ram[address_a];
      end
   end

   assert property (@(posedge clk_a) disable iff (reset)
      rden_a |-> !$isunknown(address_a));

endmodule

/* map_level1_ram.sv */
// ========================================
// Level-1 map RAM, 2048 x 5, read port A
// and write port B
// ========================================

`timescale 1ns/100ps

module map_level1_ram
(
   input  logic                 clk_a,
   input  logic                 reset,
   input  vmem_pkg::l1_addr_t   address_a,
   input  logic                 rden_a,
   input  vmem_pkg::l1_addr_t   address_b,
   input  vmem_pkg::l1_entry_t  data_b,
   input  logic                 wren_b,
   output vmem_pkg::l1_entry_t  q_a
);

   vmem_pkg::l1_entry_t ram [0:vmem_pkg::L1_DEPTH-1];
   vmem_pkg::l1_entry_t out_a;

   assign q_a = out_a;

   // Map loads land on port B
   always_ff @(posedge clk_a)
   begin
      if (wren_b)
      begin
         ram[address_b] <= data_b;
      end
   end

   // A read in the same cycle as a write to the same entry sees the old value
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         out_a <= '0;
      end
      else if (rden_a)
      begin
         out_a <= ram[address_a];
      end
   end

   assert property (@(posedge clk_a) disable iff (reset)
      rden_a |-> !$isunknown(address_a));

endmodule

/* vmem_pkg.sv */
// ========================================
// Widths, vector types and level-2 entry
// field positions for the virtual memory map
// ========================================

package vmem_pkg;

   localparam int VMA_W      = 24;
   localparam int L1_ADDR_W  = 11;
   localparam int L1_ENTRY_W = 5;
   localparam int L2_ADDR_W  = 10;
   localparam int L2_ENTRY_W = 24;
   localparam int PPN_W      = 14;
   localparam int PHYS_W     = 22;
   localparam int META_W     = 8;

   localparam int L1_DEPTH = 2048;
   localparam int L2_DEPTH = 1024;

   // Level-2 entry layout, access and write permission on top
   localparam int L2_ACCESS_BIT = 23;
   localparam int L2_WRITE_BIT  = 22;
   localparam int L2_META_HI    = 21;
   localparam int L2_META_LO    = 14;
   localparam int L2_PPN_HI     = 13;
   localparam int L2_PPN_LO     = 0;

   typedef logic [VMA_W-1:0]      vma_t;
   typedef logic [L1_ADDR_W-1:0]  l1_addr_t;
   typedef logic [L1_ENTRY_W-1:0] l1_entry_t;
   typedef logic [L2_ADDR_W-1:0]  l2_addr_t;
   typedef logic [L2_ENTRY_W-1:0] l2_entry_t;
   typedef logic [PPN_W-1:0]      ppn_t;
   typedef logic [PHYS_W-1:0]     phys_addr_t;
   typedef logic [META_W-1:0]     meta_t;

endpackage
